// File: include/quad_ctrl_config.svh
`ifndef QUAD_CTRL_CONFIG_SVH
`define QUAD_CTRL_CONFIG_SVH

// Compute engines, two AWEs of four CEs
`define QC_NUM_CE           8

// Cycles in one 3x3 window
`define QC_WINDOW_CYCLES    9

// Counter and address widths
`define QC_ROW_W            10
`define QC_PFB_CNT_W        10
`define QC_SEQ_ADDR_W       12
`define QC_KERNEL_W         5

// Input rows held in the row buffer before execution
`define QC_PRIME_ROWS       3

// Sequence BRAM strobe to first CE execute
`define QC_SEQ_RD_LATENCY   3

`endif

// File: source/quad_ctrl_pkg.sv
`include "quad_ctrl_config.svh"

package quad_ctrl_pkg;

    // Input or output row/column index
    typedef logic [`QC_ROW_W-1:0]       row_idx_t;
    // Words left in the prefetch buffer
    typedef logic [`QC_PFB_CNT_W-1:0]   pfb_cnt_t;
    typedef logic [`QC_SEQ_ADDR_W-1:0]  seq_addr_t;
    // Position inside a 3x3 window
    typedef logic [3:0]                 win_cyc_t;
    typedef logic [`QC_KERNEL_W-1:0]    kernel_idx_t;
    // One bit per compute engine
    typedef logic [`QC_NUM_CE-1:0]      ce_mask_t;

    // Job control FSM
    typedef enum logic [2:0] {
        st_idle,
        st_prime,
        st_wait_fetch,
        st_active,
        st_wait_done,
        st_send_complete
    } job_state_t;

endpackage

// File: source/job_sequencer.sv
`timescale 1ns/10ps

`include "quad_ctrl_config.svh"

module job_sequencer
    import quad_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        job_start,
    input  logic        job_fetch_ack,
    input  logic        job_fetch_complete,
    input  logic        job_complete_ack,
    input  logic        pipeline_flushed,
    input  logic        pfb_empty,
    input  logic        prime_done,
    input  logic        rows_done,
    input  logic        job_outputs_done,
    input  logic        window_end,
    output job_state_t  state,
    output logic        job_accept,
    output logic        job_fetch_request,
    output logic        job_fetch_in_progress,
    output logic        job_complete
);

    job_state_t return_state;
    logic       job_fetch_acked;
    logic       job_complete_acked;

    // Fetch is in flight from ack to complete
    always_ff @(posedge clk) begin
        if (rst) begin
            job_fetch_in_progress <= 1'b0;
        end else if (job_fetch_complete) begin
            job_fetch_in_progress <= 1'b0;
        end else if (job_fetch_ack) begin
            job_fetch_in_progress <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= st_idle;
            return_state       <= st_idle;
            job_accept         <= 1'b0;
            job_fetch_request  <= 1'b0;
            job_fetch_acked    <= 1'b0;
            job_complete       <= 1'b0;
            job_complete_acked <= 1'b0;
        end else begin
            job_accept <= 1'b0;
            case (state)
                st_idle: begin
                    job_complete_acked <= 1'b0;
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= st_prime;
                    end
                end
                st_prime: begin
                    if (pfb_empty && !rows_done) begin
                        return_state <= st_prime;
                        state        <= st_wait_fetch;
                    end else if (prime_done) begin
                        state <= st_active;
                    end
                end
                st_wait_fetch: begin
                    // Request is held until the memory side acknowledges it
                    if (job_fetch_ack) begin
                        job_fetch_request <= 1'b0;
                        job_fetch_acked   <= 1'b1;
                    end else if (!job_fetch_acked && !job_fetch_in_progress) begin
                        job_fetch_request <= 1'b1;
                    end
                    if (job_fetch_complete) begin
                        job_fetch_acked <= 1'b0;
                        state           <= return_state;
                    end
                end
                st_active: begin
                    // Decisions only on a window boundary so no window is split
                    if (window_end) begin
                        if (rows_done && job_outputs_done) begin
                            state <= st_wait_done;
                        end else if (pfb_empty && !rows_done) begin
                            return_state <= st_active;
                            state        <= st_wait_fetch;
                        end
                    end
                end
                st_wait_done: begin
                    if (pipeline_flushed) begin
                        state <= st_send_complete;
                    end
                end
                st_send_complete: begin
                    if (job_complete_ack) begin
                        job_complete       <= 1'b0;
                        job_complete_acked <= 1'b1;
                        state              <= st_idle;
                    end else if (!job_complete_acked) begin
                        job_complete <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    a_complete_in_send: assert property (@(posedge clk) disable iff (rst)
        job_complete |-> state == st_send_complete);

    // Request and transfer never overlap
    a_fetch_req_excl: assert property (@(posedge clk) disable iff (rst)
        !(job_fetch_request && job_fetch_in_progress));

endmodule

// File: source/pfb_row_reader.sv
`timescale 1ns/10ps

`include "quad_ctrl_config.svh"

module pfb_row_reader
    import quad_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  job_state_t  state,
    input  logic        job_fetch_complete,
    input  pfb_cnt_t    pfb_full_count,
    input  row_idx_t    num_expd_input_cols,
    input  row_idx_t    num_expd_input_rows,
    output logic        pfb_rden,
    output logic        next_row,
    output row_idx_t    input_row,
    output row_idx_t    input_col,
    output logic        pfb_empty,
    output logic        prime_done,
    output logic        rows_done
);

    pfb_cnt_t pfb_count;
    logic     rd_window;
    logic     col_last;

    assign pfb_empty  = (pfb_count == '0);
    // Three rows loaded and the next fetch already sitting in the buffer
    assign prime_done = (input_row == row_idx_t'(`QC_PRIME_ROWS)) &&
                        (pfb_count == pfb_full_count);
    assign rows_done  = (input_row >= num_expd_input_rows);
    assign col_last   = (input_col == num_expd_input_cols - 1'b1);

    assign rd_window = ((state == st_prime) && !prime_done) || (state == st_active);
    assign pfb_rden  = rd_window && !pfb_empty;

    always_ff @(posedge clk) begin
        if (rst || state == st_idle) begin
            pfb_count <= '0;
        end else if (job_fetch_complete) begin
            pfb_count <= pfb_full_count;
        end else if (pfb_rden) begin
            pfb_count <= pfb_count - 1'b1;
        end
    end

    // Input row and column position
    always_ff @(posedge clk) begin
        if (rst || state == st_idle) begin
            input_row <= '0;
            input_col <= '0;
            next_row  <= 1'b0;
        end else begin
            next_row <= 1'b0;
            if (pfb_rden) begin
                if (col_last) begin
                    input_col <= '0;
                    input_row <= input_row + 1'b1;
                    next_row  <= 1'b1;
                end else begin
                    input_col <= input_col + 1'b1;
                end
            end
        end
    end

    // A refill only lands on a drained buffer
    a_refill_when_empty: assert property (@(posedge clk) disable iff (rst)
        job_fetch_complete |-> pfb_empty);

endmodule

// File: source/pix_seq_reader.sv
`timescale 1ns/10ps

`include "quad_ctrl_config.svh"

module pix_seq_reader
    import quad_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  job_state_t  state,
    input  seq_addr_t   pix_seq_data_full_count,
    output logic        pix_seq_bram_rden,
    output seq_addr_t   pix_seq_bram_rdAddr,
    output win_cyc_t    cycle_counter,
    output logic        window_end
);

    localparam win_cyc_t win_last = win_cyc_t'(`QC_WINDOW_CYCLES - 1);

    seq_addr_t seq_remain;
    seq_addr_t rd_ptr;
    logic      rd_issue;
    logic      pass_end;

    // A read is issued here and seen on the BRAM port one cycle later
    assign rd_issue   = (state == st_active) && (seq_remain != '0);
    assign pass_end   = (state == st_active) && (seq_remain == '0);
    assign window_end = rd_issue && (cycle_counter == win_last);

    ////////////////////////////////////////////////////////////////////////////
    // Sequence BRAM read side
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_seq_bram_rden   <= 1'b0;
            pix_seq_bram_rdAddr <= '0;
            seq_remain          <= '0;
            rd_ptr              <= '0;
        end else begin
            pix_seq_bram_rden <= rd_issue;
            if (rd_issue) begin
                pix_seq_bram_rdAddr <= rd_ptr;
            end
            // Count is ready on entry to active, refilled after each row pass.
            // A fetch pause in the middle of a pass resumes where it stopped.
            if (state == st_prime || pass_end) begin
                seq_remain <= pix_seq_data_full_count;
                rd_ptr     <= '0;
            end else if (rd_issue) begin
                seq_remain <= seq_remain - 1'b1;
                rd_ptr     <= rd_ptr + 1'b1;
            end
        end
    end

    // Position within the current window
    always_ff @(posedge clk) begin
        if (rst || state == st_prime) begin
            cycle_counter <= '0;
        end else if (rd_issue) begin
            if (cycle_counter == win_last) begin
                cycle_counter <= '0;
            end else begin
                cycle_counter <= cycle_counter + 1'b1;
            end
        end
    end

endmodule

// File: source/ce_dispatch.sv
`timescale 1ns/10ps

`include "quad_ctrl_config.svh"

module ce_dispatch
    import quad_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  job_state_t  state,
    input  logic        pix_seq_bram_rden,
    input  logic        window_end,
    input  kernel_idx_t num_kernels,
    input  row_idx_t    num_output_cols,
    input  row_idx_t    num_output_rows,
    output ce_mask_t    ce_execute,
    output ce_mask_t    next_kernel,
    output logic        ctrl_last_kernel,
    output logic        job_outputs_done
);

    // Last stage of the latency is the ce_execute[0] flop itself
    localparam int rd_dly_len = `QC_SEQ_RD_LATENCY - 1;

    logic [rd_dly_len-1:0] rd_dly;
    kernel_idx_t           kernel_group;
    row_idx_t              output_row;
    row_idx_t              output_col;
    logic                  row_end;

    assign row_end          = (output_col == num_output_cols - 1'b1);
    assign ctrl_last_kernel = (kernel_group == num_kernels);
    assign job_outputs_done = row_end && (output_row == num_output_rows - 1'b1);

    ////////////////////////////////////////////////////////////////////////////
    // CE fan-out, one engine per cycle
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_dly      <= '0;
            ce_execute  <= '0;
            next_kernel <= '0;
        end else begin
            rd_dly[0] <= pix_seq_bram_rden;
            for (int i = 1; i < rd_dly_len; i++) begin
                rd_dly[i] <= rd_dly[i-1];
            end
            ce_execute  <= {ce_execute[`QC_NUM_CE-2:0], rd_dly[rd_dly_len-1]};
            next_kernel <= {next_kernel[`QC_NUM_CE-2:0], window_end && row_end};
        end
    end

    // Kernel group and output position, stepped per window
    always_ff @(posedge clk) begin
        if (rst || state == st_idle) begin
            kernel_group <= '0;
            output_row   <= '0;
            output_col   <= '0;
        end else if (window_end) begin
            if (ctrl_last_kernel) begin
                kernel_group <= '0;
            end else begin
                kernel_group <= kernel_group + 1'b1;
            end
            if (row_end) begin
                output_col <= '0;
                output_row <= output_row + 1'b1;
            end else begin
                output_col <= output_col + 1'b1;
            end
        end
    end

    // No window arrives once the last output row is done
    a_no_window_past_end: assert property (@(posedge clk) disable iff (rst)
        window_end |-> output_row < num_output_rows);

endmodule

// File: source/quad_bram_ctrl.sv
`timescale 1ns/10ps

`include "quad_ctrl_config.svh"

module quad_bram_ctrl
    import quad_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        job_start,
    input  logic        job_fetch_ack,
    input  logic        job_fetch_complete,
    input  logic        job_complete_ack,
    input  logic        pipeline_flushed,
    input  row_idx_t    num_expd_input_cols,
    input  row_idx_t    num_expd_input_rows,
    input  row_idx_t    num_output_rows,
    input  row_idx_t    num_output_cols,
    input  pfb_cnt_t    pfb_full_count,
    input  seq_addr_t   pix_seq_data_full_count,
    input  kernel_idx_t num_kernels,
    output logic        job_accept,
    output logic        job_fetch_request,
    output logic        job_fetch_in_progress,
    output logic        job_complete,
    output logic        pfb_rden,
    output logic        next_row,
    output logic        pix_seq_bram_rden,
    output logic        ctrl_last_kernel,
    output job_state_t  state,
    output row_idx_t    input_row,
    output row_idx_t    input_col,
    output seq_addr_t   pix_seq_bram_rdAddr,
    output win_cyc_t    cycle_counter,
    output ce_mask_t    ce_execute,
    output ce_mask_t    next_kernel
);

    logic pfb_empty;
    logic prime_done;
    logic rows_done;
    logic window_end;
    logic job_outputs_done;

    ////////////////////////////////////////////////////////////////////////////
    // Job control
    ////////////////////////////////////////////////////////////////////////////

    job_sequencer i_job_sequencer (
        .clk                    (clk),
        .rst                    (rst),
        .job_start              (job_start),
        .job_fetch_ack          (job_fetch_ack),
        .job_fetch_complete     (job_fetch_complete),
        .job_complete_ack       (job_complete_ack),
        .pipeline_flushed       (pipeline_flushed),
        .pfb_empty              (pfb_empty),
        .prime_done             (prime_done),
        .rows_done              (rows_done),
        .job_outputs_done       (job_outputs_done),
        .window_end             (window_end),
        .state                  (state),
        .job_accept             (job_accept),
        .job_fetch_request      (job_fetch_request),
        .job_fetch_in_progress  (job_fetch_in_progress),
        .job_complete           (job_complete)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory side readers and CE fan-out
    ////////////////////////////////////////////////////////////////////////////

    pfb_row_reader i_pfb_row_reader (
        .clk                    (clk),
        .rst                    (rst),
        .state                  (state),
        .job_fetch_complete     (job_fetch_complete),
        .pfb_full_count         (pfb_full_count),
        .num_expd_input_cols    (num_expd_input_cols),
        .num_expd_input_rows    (num_expd_input_rows),
        .pfb_rden               (pfb_rden),
        .next_row               (next_row),
        .input_row              (input_row),
        .input_col              (input_col),
        .pfb_empty              (pfb_empty),
        .prime_done             (prime_done),
        .rows_done              (rows_done)
    );

    pix_seq_reader i_pix_seq_reader (
        .clk                        (clk),
        .rst                        (rst),
        .state                      (state),
        .pix_seq_data_full_count    (pix_seq_data_full_count),
        .pix_seq_bram_rden          (pix_seq_bram_rden),
        .pix_seq_bram_rdAddr        (pix_seq_bram_rdAddr),
        .cycle_counter              (cycle_counter),
        .window_end                 (window_end)
    );

    ce_dispatch i_ce_dispatch (
        .clk                (clk),
        .rst                (rst),
        .state              (state),
        .pix_seq_bram_rden  (pix_seq_bram_rden),
        .window_end         (window_end),
        .num_kernels        (num_kernels),
        .num_output_cols    (num_output_cols),
        .num_output_rows    (num_output_rows),
        .ce_execute         (ce_execute),
        .next_kernel        (next_kernel),
        .ctrl_last_kernel   (ctrl_last_kernel),
        .job_outputs_done   (job_outputs_done)
    );

endmodule

// File: testbench/quad_ctrl_tb.sv
`timescale 1ns/10ps

`include "quad_ctrl_config.svh"

module quad_ctrl_tb
    import quad_ctrl_pkg::*;
();

    localparam int cond_accept    = 0;
    localparam int cond_active    = 1;
    localparam int cond_wait_done = 2;
    localparam int cond_flushed   = 3;
    localparam int cond_complete  = 4;
    localparam int cond_idle      = 5;

    logic        clk;
    logic        rst                     = 1'b1;
    logic        job_start               = 1'b0;
    logic        job_fetch_ack           = 1'b0;
    logic        job_fetch_complete      = 1'b0;
    logic        job_complete_ack        = 1'b0;
    logic        pipeline_flushed        = 1'b0;
    row_idx_t    num_expd_input_cols     = '0;
    row_idx_t    num_expd_input_rows     = '0;
    row_idx_t    num_output_rows         = '0;
    row_idx_t    num_output_cols         = '0;
    pfb_cnt_t    pfb_full_count          = '0;
    seq_addr_t   pix_seq_data_full_count = '0;
    kernel_idx_t num_kernels             = '0;

    logic        job_accept;
    logic        job_fetch_request;
    logic        job_fetch_in_progress;
    logic        job_complete;
    logic        pfb_rden;
    logic        next_row;
    logic        pix_seq_bram_rden;
    logic        ctrl_last_kernel;
    job_state_t  state;
    row_idx_t    input_row;
    row_idx_t    input_col;
    seq_addr_t   pix_seq_bram_rdAddr;
    win_cyc_t    cycle_counter;
    ce_mask_t    ce_execute;
    ce_mask_t    next_kernel;

    // Fetch responder
    logic [1:0]  fetch_phase;
    logic [2:0]  fetch_wait;
    logic [31:0] rand_state;
    logic [31:0] next_rand;

    // Reference model state
    logic        accept_exp;
    logic        req_q;
    logic        ack_q;
    logic        fcpl_q;
    logic        busy_model;
    logic        complete_q;
    logic        cack_q;
    job_state_t  state_q;
    win_cyc_t    cc_q;
    win_cyc_t    cc_exp;
    ce_mask_t    ce_exec_q;
    ce_mask_t    nk_q;
    logic [2:0]  rden_hist;
    int          win_rds;
    kernel_idx_t kg_model;
    row_idx_t    ocol_model;
    logic        nk0_exp;
    row_idx_t    row_model;
    row_idx_t    col_model;
    logic        nr_model;
    seq_addr_t   exp_addr;
    int          fill_reads;
    logic        fill_seen;

    int          mismatches = 0;
    int          timeouts   = 0;
    logic        timed_out  = 1'b0;
    string       cur_job    = "reset";

    quad_bram_ctrl i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] seed);
        return seed * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_mismatch(input string check, input int expected, input int actual);
        mismatches++;
        $display("ERROR [%s] %s: expected %0d, actual %0d", cur_job, check, expected, actual);
    endtask

    function automatic bit cond_met(input int cond);
        case (cond)
            cond_accept:    return job_accept;
            cond_active:    return state == st_active;
            cond_wait_done: return state == st_wait_done;
            cond_flushed:   return ce_execute == '0 && !pix_seq_bram_rden && rden_hist == '0;
            cond_complete:  return job_complete;
            cond_idle:      return state == st_idle;
            default:        return 1'b0;
        endcase
    endfunction

    task automatic wait_until(input int cond, input int limit, input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!cond_met(cond) && n < limit);
        if (!cond_met(cond)) begin
            timeouts++;
            timed_out = 1'b1;
            $display("[%s] Timed out after %0d cycles waiting for %s", cur_job, limit, what);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory side fetch responder
    ////////////////////////////////////////////////////////////////////////////

    // Ack after 1 to 4 cycles, then the fetch completes 3 cycles later
    always @(posedge clk) begin
        if (rst) begin
            fetch_phase        <= 2'd0;
            fetch_wait         <= 3'd0;
            rand_state         <= 32'd1;
            job_fetch_ack      <= 1'b0;
            job_fetch_complete <= 1'b0;
        end else begin
            job_fetch_ack      <= 1'b0;
            job_fetch_complete <= 1'b0;
            case (fetch_phase)
                2'd0: begin
                    if (job_fetch_request) begin
                        next_rand   = lcg_next(rand_state);
                        rand_state  <= next_rand;
                        fetch_wait  <= 3'd1 + {1'b0, next_rand[17:16]};
                        fetch_phase <= 2'd1;
                    end
                end
                2'd1: begin
                    if (fetch_wait == 3'd1) begin
                        job_fetch_ack <= 1'b1;
                        fetch_wait    <= 3'd3;
                        fetch_phase   <= 2'd2;
                    end else begin
                        fetch_wait <= fetch_wait - 1'b1;
                    end
                end
                2'd2: begin
                    if (fetch_wait == 3'd1) begin
                        job_fetch_complete <= 1'b1;
                        fetch_phase        <= 2'd3;
                    end else begin
                        fetch_wait <= fetch_wait - 1'b1;
                    end
                end
                default: begin
                    fetch_phase <= 2'd0;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks, one cycle of DUT outputs per clock edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            accept_exp <= 1'b0;
            req_q      <= 1'b0;
            ack_q      <= 1'b0;
            fcpl_q     <= 1'b0;
            complete_q <= 1'b0;
            cack_q     <= 1'b0;
            state_q    <= st_idle;
            cc_q       <= '0;
            ce_exec_q  <= '0;
            nk_q       <= '0;
            rden_hist  <= '0;
            busy_model = 1'b0;
            win_rds    = 0;
            kg_model   = '0;
            ocol_model = '0;
            nk0_exp    = 1'b0;
            row_model  = '0;
            col_model  = '0;
            nr_model   = 1'b0;
            exp_addr   = '0;
            fill_reads = 0;
            fill_seen  = 1'b0;
        end else begin
            assert (job_accept == accept_exp)
                else report_mismatch("job_accept", accept_exp, job_accept);

            // Request held until ack, dropped the cycle after
            if (req_q) begin
                assert (job_fetch_request == !ack_q)
                    else report_mismatch("job_fetch_request", !ack_q, job_fetch_request);
            end

            // Transfer flag from the cycle after ack to the cycle after complete
            if (fcpl_q) begin
                busy_model = 1'b0;
            end else if (ack_q) begin
                busy_model = 1'b1;
            end
            assert (job_fetch_in_progress == busy_model)
                else report_mismatch("job_fetch_in_progress", busy_model,
                                     job_fetch_in_progress);

            // PFB reads per fill
            if (job_accept) begin
                fill_seen = 1'b0;
            end
            if (job_fetch_complete || (state == st_wait_done && state_q != st_wait_done)) begin
                if (fill_seen) begin
                    assert (fill_reads == pfb_full_count)
                        else report_mismatch("pfb reads per fetch", pfb_full_count, fill_reads);
                end
                fill_reads = 0;
                fill_seen  = job_fetch_complete;
            end
            if (pfb_rden) begin
                fill_reads++;
            end

            // Input position steps on each PFB read
            assert (input_col == col_model)
                else report_mismatch("input_col", col_model, input_col);
            assert (input_row == row_model)
                else report_mismatch("input_row", row_model, input_row);
            assert (next_row == nr_model)
                else report_mismatch("next_row", nr_model, next_row);
            nr_model = 1'b0;
            if (state == st_idle) begin
                row_model = '0;
                col_model = '0;
            end else if (pfb_rden) begin
                if (col_model == num_expd_input_cols - 1'b1) begin
                    col_model = '0;
                    row_model = row_model + 1'b1;
                    nr_model  = 1'b1;
                end else begin
                    col_model = col_model + 1'b1;
                end
            end

            assert (ce_execute[0] == rden_hist[2])
                else report_mismatch("ce_execute[0] latency", rden_hist[2], ce_execute[0]);
            for (int i = 1; i < `QC_NUM_CE; i++) begin
                assert (ce_execute[i] == ce_exec_q[i-1])
                    else report_mismatch($sformatf("ce_execute[%0d]", i),
                                         ce_exec_q[i-1], ce_execute[i]);
                assert (next_kernel[i] == nk_q[i-1])
                    else report_mismatch($sformatf("next_kernel[%0d]", i),
                                         nk_q[i-1], next_kernel[i]);
            end

            // Window position, cleared while priming
            if (state_q == st_prime) begin
                cc_exp = '0;
            end else if (pix_seq_bram_rden) begin
                cc_exp = (cc_q == win_cyc_t'(`QC_WINDOW_CYCLES - 1)) ? '0 : cc_q + 1'b1;
            end else begin
                cc_exp = cc_q;
            end
            assert (cycle_counter == cc_exp)
                else report_mismatch("cycle_counter", cc_exp, cycle_counter);

            // Linear sequence addresses, restarting after each full pass
            if (state_q == st_prime) begin
                exp_addr = '0;
            end
            if (pix_seq_bram_rden) begin
                assert (pix_seq_bram_rdAddr == exp_addr)
                    else report_mismatch("pix_seq_bram_rdAddr", exp_addr, pix_seq_bram_rdAddr);
                exp_addr = (exp_addr + 1 == pix_seq_data_full_count) ? '0 : exp_addr + 1'b1;
            end

            // Kernel group counted in windows of nine reads
            if (state_q == st_idle) begin
                kg_model   = '0;
                ocol_model = '0;
            end
            if (state_q == st_prime) begin
                win_rds = 0;
            end
            nk0_exp = 1'b0;
            if (pix_seq_bram_rden) begin
                win_rds++;
                if (win_rds == `QC_WINDOW_CYCLES) begin
                    win_rds  = 0;
                    kg_model = (kg_model == num_kernels) ? '0 : kg_model + 1'b1;
                    // Last window of an output row
                    if (ocol_model == num_output_cols - 1'b1) begin
                        ocol_model = '0;
                        nk0_exp    = 1'b1;
                    end else begin
                        ocol_model = ocol_model + 1'b1;
                    end
                end
            end
            assert (ctrl_last_kernel == (kg_model == num_kernels))
                else report_mismatch("ctrl_last_kernel", kg_model == num_kernels,
                                     ctrl_last_kernel);
            assert (next_kernel[0] == nk0_exp)
                else report_mismatch("next_kernel[0]", nk0_exp, next_kernel[0]);

            if (complete_q && !cack_q) begin
                assert (job_complete)
                    else report_mismatch("job_complete held", 1, job_complete);
            end
            if (complete_q && cack_q) begin
                assert (!job_complete)
                    else report_mismatch("job_complete after ack", 0, job_complete);
                assert (state == st_idle)
                    else report_mismatch("state after ack", st_idle, state);
            end
            if (state_q == st_idle) begin
                assert (input_row == '0)
                    else report_mismatch("input_row in idle", 0, input_row);
                assert (input_col == '0)
                    else report_mismatch("input_col in idle", 0, input_col);
            end

            accept_exp <= job_start && (state == st_idle);
            req_q      <= job_fetch_request;
            ack_q      <= job_fetch_ack;
            fcpl_q     <= job_fetch_complete;
            complete_q <= job_complete;
            cack_q     <= job_complete_ack;
            state_q    <= state;
            cc_q       <= cycle_counter;
            ce_exec_q  <= ce_execute;
            nk_q       <= next_kernel;
            rden_hist  <= {rden_hist[1:0], pix_seq_bram_rden};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Job stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_job(input string name, input row_idx_t in_cols, input row_idx_t in_rows,
                           input row_idx_t out_cols, input row_idx_t out_rows,
                           input pfb_cnt_t pfb_words, input seq_addr_t seq_words,
                           input kernel_idx_t kernels);
        cur_job = name;
        num_expd_input_cols     <= in_cols;
        num_expd_input_rows     <= in_rows;
        num_output_cols         <= out_cols;
        num_output_rows         <= out_rows;
        pfb_full_count          <= pfb_words;
        pix_seq_data_full_count <= seq_words;
        num_kernels             <= kernels;
        @(posedge clk);
        job_start <= 1'b1;
        @(posedge clk);
        job_start <= 1'b0;
        wait_until(cond_accept, 8, "job_accept");
        if (timed_out) return;
        wait_until(cond_active, 1000, "end of row priming");
        if (timed_out) return;
        // Start while busy, no accept expected
        job_start <= 1'b1;
        @(posedge clk);
        job_start <= 1'b0;
        wait_until(cond_wait_done, 4000, "all outputs");
        if (timed_out) return;
        wait_until(cond_flushed, 40, "CE pipeline to drain");
        if (timed_out) return;
        pipeline_flushed <= 1'b1;
        wait_until(cond_complete, 20, "job_complete");
        if (timed_out) return;
        repeat (2) @(posedge clk);
        job_complete_ack <= 1'b1;
        @(posedge clk);
        job_complete_ack <= 1'b0;
        pipeline_flushed <= 1'b0;
        wait_until(cond_idle, 8, "return to idle");
    endtask

    initial begin
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        // One input row per fetch
        run_job("job_6x6_k2", 10'd6, 10'd6, 10'd4, 10'd4, 10'd6, 12'd36, 5'd2);
        // Three input rows per fetch
        if (!timed_out) begin
            run_job("job_5x8_k3", 10'd5, 10'd8, 10'd3, 10'd6, 10'd15, 12'd27, 5'd3);
        end
        repeat (4) @(posedge clk);
        $display("Checks done: %0d value errors, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
source/quad_ctrl_pkg.sv
source/job_sequencer.sv
source/pfb_row_reader.sv
source/pix_seq_reader.sv
source/ce_dispatch.sv
source/quad_bram_ctrl.sv
testbench/quad_ctrl_tb.sv
